// File: verilog/maskmem_pkg.sv
// maskmem shared types

package maskmem_pkg;

   // width of a data word and of the per-bit write mask
   localparam int MASKMEM_DATA_W = 32;

   // word address width, enough to reach every entry of the memory
   localparam int MASKMEM_ADDR_W = 6;

   // number of words in the memory
   // the top level hands this to the memory as els_p
   localparam int MASKMEM_DEPTH = 64;

   // command opcodes
   // read returns the word, the other three change only the masked bits
   typedef enum logic [1:0] {
      OP_READ  = 2'd0,
      OP_WRITE = 2'd1,
      OP_SET   = 2'd2,
      OP_CLEAR = 2'd3
   } maskmem_op_e;

   // one command as it arrives on the external port, 72 bits
   // op sits in the top bits and the mask in the bottom bits
   typedef struct packed {
      maskmem_op_e                op;
      logic [MASKMEM_ADDR_W-1:0]  addr;
      logic [MASKMEM_DATA_W-1:0]  data;
      logic [MASKMEM_DATA_W-1:0]  mask;
   } maskmem_cmd_s;

   // one response, 34 bits
   // data is always the memory's read register, so writes report the last read
   typedef struct packed {
      maskmem_op_e                op;
      logic [MASKMEM_DATA_W-1:0]  data;
   } maskmem_rsp_s;

endpackage

// File: verilog/maskmem_sram.sv
// single-port ram with bit write mask
`timescale 1ns/10ps

module maskmem_sram #(
   parameter int width_p = 32,
   parameter int els_p = 64,
   // a one-word memory still gets a one-bit address
   localparam int addr_width_lp = (els_p > 1) ? $clog2(els_p) : 1
) (
   input  logic                     clk_i,
   input  logic                     reset_i,
   // one access per cycle, v_i qualifies it and w_i picks write over read
   input  logic                     v_i,
   input  logic                     w_i,
   input  logic [addr_width_lp-1:0] addr_i,
   input  logic [width_p-1:0]       data_i,
   // a one in the mask lets the matching data bit through on a write
   input  logic [width_p-1:0]       w_mask_i,
   // read register, it keeps the last word read until the next read
   output logic [width_p-1:0]       data_o
);

   // storage array
   logic [width_p-1:0] mem [els_p];

   // access decode
   logic read_en;
   logic write_en;

   // new value of the addressed word on a masked write
   logic [width_p-1:0] write_word;

   assign read_en = v_i & ~w_i;
   assign write_en = v_i & w_i;

   // merge the incoming bits with the stored ones, bit by bit
   // unmasked bits keep what the word already held
   assign write_word = (data_i & w_mask_i) | (mem[addr_i] & ~w_mask_i);

   // the array is only written, never cleared
   // its contents after reset are whatever was there before
   always_ff @(posedge clk_i)
   begin
      if (write_en)
      begin
         mem[addr_i] <= write_word;
      end
   end

   // the read register updates only on a read
   // writes and idle cycles leave it alone, so it holds the last read value
   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         data_o <= '0;
      end
      else if (read_en)
      begin
         data_o <= mem[addr_i];
      end
   end

endmodule

// File: verilog/maskmem_cmd_port.sv
// four-phase command receiver
`timescale 1ns/10ps

module maskmem_cmd_port
   import maskmem_pkg::*;
(
   input  logic         clk_i,
   input  logic         reset_i,
   // external four-phase side, the producer holds cmd_i while cmd_req_i is high
   input  logic         cmd_req_i,
   input  maskmem_cmd_s cmd_i,
   output logic         cmd_ack_o,
   // internal valid/ready side toward the operation unit
   output logic         cmd_valid_o,
   output maskmem_cmd_s cmd_o,
   input  logic         cmd_ready_i
);

   // IDLE waits for a request with the buffer empty
   // HOLD keeps ack high until the producer drops its request
   // WAIT_DROP has ack low again but the buffer has not drained yet
   typedef enum logic [1:0] {IDLE, HOLD, WAIT_DROP} state_e;

   state_e state_r;
   state_e state_n;

   // one-entry command buffer and its full flag
   maskmem_cmd_s cmd_r;
   logic         valid_r;

   logic capture;
   logic take;
   // true when the buffer will be empty after this edge
   logic buf_free;

   // a request is only honoured from IDLE, where the buffer is known empty
   assign capture = (state_r == IDLE) & cmd_req_i;
   assign take = valid_r & cmd_ready_i;
   assign buf_free = ~valid_r | cmd_ready_i;

   always_comb
   begin
      state_n = state_r;
      case (state_r)
         IDLE:
         begin
            if (cmd_req_i)
            begin
               state_n = HOLD;
            end
         end
         HOLD:
         begin
            // ack falls one cycle after the request is seen low
            // skip WAIT_DROP when the command has already moved on
            if (!cmd_req_i)
            begin
               state_n = buf_free ? IDLE : WAIT_DROP;
            end
         end
         WAIT_DROP:
         begin
            if (buf_free)
            begin
               state_n = IDLE;
            end
         end
         default:
         begin
            state_n = IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r <= IDLE;
         valid_r <= 1'b0;
      end
      else
      begin
         state_r <= state_n;
         // capture and take never meet, capture needs an empty buffer
         if (capture)
         begin
            valid_r <= 1'b1;
         end
         else if (take)
         begin
            valid_r <= 1'b0;
         end
      end
   end

   // payload is sampled at the edge where the request is first seen
   always_ff @(posedge clk_i)
   begin
      if (capture)
      begin
         cmd_r <= cmd_i;
      end
   end

   // ack and valid both come up right after the capture edge
   assign cmd_ack_o = (state_r == HOLD);
   assign cmd_valid_o = valid_r;
   assign cmd_o = cmd_r;

endmodule

// File: verilog/maskmem_op_unit.sv
// opcode decode and memory access
`timescale 1ns/10ps

module maskmem_op_unit
   import maskmem_pkg::*;
#(
   parameter int width_p = MASKMEM_DATA_W,
   parameter int els_p = MASKMEM_DEPTH
) (
   input  logic         clk_i,
   input  logic         reset_i,
   // commands from the input side
   input  logic         cmd_valid_i,
   input  maskmem_cmd_s cmd_i,
   output logic         cmd_ready_o,
   // responses to the output side
   output logic         rsp_valid_o,
   output maskmem_rsp_s rsp_o,
   input  logic         rsp_ready_i
);

   // IDLE accepts a command, ACCESS drives the memory for one cycle,
   // RESPOND holds the response until the output side takes it
   typedef enum logic [1:0] {IDLE, ACCESS, RESPOND} state_e;

   state_e state_r;

   // command being worked on
   maskmem_cmd_s cmd_r;

   logic accept;

   // memory controls
   logic               mem_v;
   logic               mem_w;
   logic [width_p-1:0] mem_data_li;
   logic [width_p-1:0] mem_mask_li;
   logic [width_p-1:0] mem_data_lo;

   // a new command is taken only in IDLE
   // so cmd_ready stays low while a response waits in RESPOND
   assign cmd_ready_o = (state_r == IDLE);
   assign accept = cmd_valid_i & cmd_ready_o;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r <= IDLE;
      end
      else
      begin
         case (state_r)
            IDLE:
            begin
               if (accept)
               begin
                  state_r <= ACCESS;
               end
            end
            // single access cycle, data_o is valid right after it
            ACCESS:
            begin
               state_r <= RESPOND;
            end
            RESPOND:
            begin
               if (rsp_ready_i)
               begin
                  state_r <= IDLE;
               end
            end
            default:
            begin
               state_r <= IDLE;
            end
         endcase
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (accept)
      begin
         cmd_r <= cmd_i;
      end
   end

   // set and clear are masked writes of a constant word
   always_comb
   begin
      mem_w = 1'b1;
      mem_data_li = cmd_r.data;
      mem_mask_li = cmd_r.mask;
      case (cmd_r.op)
         OP_READ:
         begin
            mem_w = 1'b0;
            mem_mask_li = '0;
         end
         OP_SET:
         begin
            mem_data_li = '1;
         end
         OP_CLEAR:
         begin
            mem_data_li = '0;
         end
         default:
         begin
            mem_w = 1'b1;
         end
      endcase
   end

   assign mem_v = (state_r == ACCESS);

   maskmem_sram #(
      .width_p(width_p),
      .els_p(els_p)
   ) sram_i (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .v_i(mem_v),
      .w_i(mem_w),
      .addr_i(cmd_r.addr),
      .data_i(mem_data_li),
      .w_mask_i(mem_mask_li),
      .data_o(mem_data_lo)
   );

   // the read register is stable from the end of ACCESS until the next read
   assign rsp_valid_o = (state_r == RESPOND);
   assign rsp_o.op = cmd_r.op;
   assign rsp_o.data = mem_data_lo;

endmodule

// File: verilog/maskmem_rsp_port.sv
// four-phase response sender
`timescale 1ns/10ps

module maskmem_rsp_port
   import maskmem_pkg::*;
(
   input  logic         clk_i,
   input  logic         reset_i,
   // internal valid/ready side from the operation unit
   input  logic         rsp_valid_i,
   input  maskmem_rsp_s rsp_i,
   output logic         rsp_ready_o,
   // external four-phase side, this block is the producer
   output logic         rsp_req_o,
   output maskmem_rsp_s rsp_o,
   input  logic         rsp_ack_i
);

   // IDLE is ready for a response
   // REQ raises the request and waits for ack
   // WAIT_DROP has the request low and waits for ack to fall
   typedef enum logic [1:0] {IDLE, REQ, WAIT_DROP} state_e;

   state_e state_r;

   // response held on rsp_o for the whole handshake
   maskmem_rsp_s rsp_r;

   logic capture;

   // no new response until the consumer has dropped its ack
   assign rsp_ready_o = (state_r == IDLE);
   assign capture = rsp_valid_i & rsp_ready_o;

   always_ff @(posedge clk_i)
   begin
      if (reset_i)
      begin
         state_r <= IDLE;
      end
      else
      begin
         case (state_r)
            IDLE:
            begin
               if (capture)
               begin
                  state_r <= REQ;
               end
            end
            // req drops one cycle after ack is seen high
            REQ:
            begin
               if (rsp_ack_i)
               begin
                  state_r <= WAIT_DROP;
               end
            end
            WAIT_DROP:
            begin
               if (!rsp_ack_i)
               begin
                  state_r <= IDLE;
               end
            end
            default:
            begin
               state_r <= IDLE;
            end
         endcase
      end
   end

   // loaded only from IDLE, so it cannot move while req is high
   always_ff @(posedge clk_i)
   begin
      if (capture)
      begin
         rsp_r <= rsp_i;
      end
   end

   assign rsp_req_o = (state_r == REQ);
   assign rsp_o = rsp_r;

endmodule

// File: verilog/maskmem_top.sv
// masked-write memory top level
`timescale 1ns/10ps

module maskmem_top
   import maskmem_pkg::*;
(
   input  logic         clk_i,
   input  logic         reset_i,
   // command port, four-phase with the DUT as consumer
   input  logic         cmd_req_i,
   input  maskmem_cmd_s cmd_i,
   output logic         cmd_ack_o,
   // response port, four-phase with the DUT as producer
   output logic         rsp_req_o,
   output maskmem_rsp_s rsp_o,
   input  logic         rsp_ack_i
);

   // command transfer from the input side to the operation unit
   logic         cmd_valid;
   logic         cmd_ready;
   maskmem_cmd_s cmd;

   // response transfer from the operation unit to the output side
   logic         rsp_valid;
   logic         rsp_ready;
   maskmem_rsp_s rsp;

   maskmem_cmd_port cmd_port_i (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .cmd_req_i(cmd_req_i),
      .cmd_i(cmd_i),
      .cmd_ack_o(cmd_ack_o),
      .cmd_valid_o(cmd_valid),
      .cmd_o(cmd),
      .cmd_ready_i(cmd_ready)
   );

   // memory geometry comes from the package and rides down to the ram
   maskmem_op_unit #(
      .width_p(MASKMEM_DATA_W),
      .els_p(MASKMEM_DEPTH)
   ) op_unit_i (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .cmd_valid_i(cmd_valid),
      .cmd_i(cmd),
      .cmd_ready_o(cmd_ready),
      .rsp_valid_o(rsp_valid),
      .rsp_o(rsp),
      .rsp_ready_i(rsp_ready)
   );

   maskmem_rsp_port rsp_port_i (
      .clk_i(clk_i),
      .reset_i(reset_i),
      .rsp_valid_i(rsp_valid),
      .rsp_i(rsp),
      .rsp_ready_o(rsp_ready),
      .rsp_req_o(rsp_req_o),
      .rsp_o(rsp_o),
      .rsp_ack_i(rsp_ack_i)
   );

endmodule

// File: sim/maskmem_checker.sv
// maskmem response checker
`timescale 1ns/10ps

module maskmem_checker
   import maskmem_pkg::*;
(
   input  logic         clk_i,
   input  logic         reset_i,
   // DUT ports, watched only
   input  logic         cmd_req_i,
   input  logic         cmd_ack_i,
   input  logic         rsp_req_i,
   input  maskmem_rsp_s rsp_i,
   input  logic         rsp_ack_i,
   // expected responses from the reference model, one per pulse
   input  logic         exp_push_i,
   input  maskmem_rsp_s exp_rsp_i,
   input  logic         end_check_i,
   output int           err_cnt_o,
   output int           cmd_cnt_o,
   output int           rsp_cnt_o
);

   maskmem_rsp_s exp_q [$];
   maskmem_rsp_s exp;
   maskmem_rsp_s prev_rsp;
   int   err_cnt = 0;
   int   cmd_cnt = 0;
   int   rsp_cnt = 0;
   logic prev_reset = 1'b1;
   logic prev_ack = 1'b0;
   logic prev_req = 1'b0;
   // a command has been acknowledged and its response handshake is not over
   logic outstanding = 1'b0;
   logic end_done = 1'b0;

   assign err_cnt_o = err_cnt;
   assign cmd_cnt_o = cmd_cnt;
   assign rsp_cnt_o = rsp_cnt;

   // everything is sampled on the falling edge, half a cycle away from the driver
   always @(negedge clk_i)
   begin
      if (exp_push_i)
         exp_q.push_back(exp_rsp_i);
      // both request lines must come out of reset low
      if (prev_reset && !reset_i)
      begin
         if (cmd_ack_i !== 1'b0)
         begin
            $display("Mismatch cmd_ack_o after reset: got %h expected 0", cmd_ack_i);
            err_cnt++;
         end
         if (rsp_req_i !== 1'b0)
         begin
            $display("Mismatch rsp_req_o after reset: got %h expected 0", rsp_req_i);
            err_cnt++;
         end
      end
      if (!reset_i && cmd_ack_i && !prev_ack)
      begin
         cmd_cnt++;
         if (!cmd_req_i)
         begin
            $display("cmd_ack_o rose while cmd_req_i was low");
            err_cnt++;
         end
         if (outstanding)
         begin
            $display("cmd_ack_o rose before the previous response handshake ended");
            err_cnt++;
         end
         outstanding = 1'b1;
      end
      if (!reset_i && rsp_req_i && !prev_req)
      begin
         rsp_cnt++;
         if (exp_q.size() == 0)
         begin
            $display("response %0d arrived with no command waiting for it", rsp_cnt);
            err_cnt++;
         end
         else
         begin
            exp = exp_q.pop_front();
            if (rsp_i.op !== exp.op)
            begin
               $display("Mismatch rsp_o.op in response %0d: got %h expected %h",
                        rsp_cnt, rsp_i.op, exp.op);
               err_cnt++;
            end
            if (rsp_i.data !== exp.data)
            begin
               $display("Mismatch rsp_o.data in response %0d: got %h expected %h",
                        rsp_cnt, rsp_i.data, exp.data);
               err_cnt++;
            end
         end
      end
      if (rsp_req_i && prev_req && rsp_i !== prev_rsp)
      begin
         $display("rsp_o changed while rsp_req_o was high, %h became %h", prev_rsp, rsp_i);
         err_cnt++;
      end
      // the request may only fall once the consumer has acknowledged
      if (!rsp_req_i && prev_req)
      begin
         if (!rsp_ack_i)
         begin
            $display("rsp_req_o dropped before rsp_ack_i was raised");
            err_cnt++;
         end
         outstanding = 1'b0;
      end
      if (end_check_i && !end_done)
      begin
         end_done = 1'b1;
         if (exp_q.size() != 0 || cmd_cnt != rsp_cnt)
         begin
            $display("%0d commands acknowledged but %0d responses seen, %0d still expected",
                     cmd_cnt, rsp_cnt, exp_q.size());
            err_cnt++;
         end
      end
      prev_reset = reset_i;
      prev_ack = cmd_ack_i;
      prev_req = rsp_req_i;
      prev_rsp = rsp_i;
   end

endmodule

// File: sim/maskmem_tb.sv
// maskmem testbench top
`timescale 1ns/10ps

module maskmem_tb
   import maskmem_pkg::*;
();

   localparam int reset_cycles = 16;
   localparam int n_reads_after_fill = 8;
   localparam int n_masked = 40;
   localparam int n_set_clear = 40;
   localparam int n_hold = 40;
   localparam int n_backpressure = 30;
   localparam int n_mix = 300;
   // tests 2 and 3 read back every address they touched
   localparam int total_cmds = MASKMEM_DEPTH + n_reads_after_fill + 2 * n_masked
                               + 2 * n_set_clear + n_hold + n_backpressure + n_mix;
   localparam int timeout_limit = reset_cycles + 40 * total_cmds;

   logic         clk;
   logic         reset;
   logic         cmd_req;
   maskmem_cmd_s cmd;
   logic         cmd_ack;
   logic         rsp_req;
   maskmem_rsp_s rsp;
   logic         rsp_ack;
   logic         exp_push;
   maskmem_rsp_s exp_rsp;
   logic         end_check;
   int           err_cnt;
   int           cmd_cnt;
   int           rsp_cnt;

   integer seed = 68330;
   int     max_gap;
   int     max_ack_delay;
   int     n_sent;
   int     cycle_cnt;

   // reference model, the last-read register starts at zero like the DUT
   logic [MASKMEM_DATA_W-1:0] model_mem [MASKMEM_DEPTH];
   logic [MASKMEM_DATA_W-1:0] model_last;
   logic [MASKMEM_ADDR_W-1:0] touched_q [$];

   maskmem_top maskmem_top_i (
      .clk_i(clk),
      .reset_i(reset),
      .cmd_req_i(cmd_req),
      .cmd_i(cmd),
      .cmd_ack_o(cmd_ack),
      .rsp_req_o(rsp_req),
      .rsp_o(rsp),
      .rsp_ack_i(rsp_ack)
   );

   maskmem_checker checker_i (
      .clk_i(clk),
      .reset_i(reset),
      .cmd_req_i(cmd_req),
      .cmd_ack_i(cmd_ack),
      .rsp_req_i(rsp_req),
      .rsp_i(rsp),
      .rsp_ack_i(rsp_ack),
      .exp_push_i(exp_push),
      .exp_rsp_i(exp_rsp),
      .end_check_i(end_check),
      .err_cnt_o(err_cnt),
      .cmd_cnt_o(cmd_cnt),
      .rsp_cnt_o(rsp_cnt)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // a read loads the register, the other opcodes touch only masked bits
   task automatic model_apply(input maskmem_cmd_s c, output maskmem_rsp_s r);
      case (c.op)
         OP_READ:  model_last = model_mem[c.addr];
         OP_WRITE: model_mem[c.addr] = (model_mem[c.addr] & ~c.mask) | (c.data & c.mask);
         OP_SET:   model_mem[c.addr] = model_mem[c.addr] | c.mask;
         default:  model_mem[c.addr] = model_mem[c.addr] & ~c.mask;
      endcase
      r.op = c.op;
      r.data = model_last;
   endtask

   task automatic rand_cmd(input maskmem_op_e op, output maskmem_cmd_s c);
      c.op = op;
      c.addr = MASKMEM_ADDR_W'($random(seed));
      c.data = $random(seed);
      c.mask = $random(seed);
   endtask

   task automatic pick_op(input logic allow_read, output maskmem_op_e op);
      if (allow_read)
         op = maskmem_op_e'(2'($random(seed)));
      else
         op = maskmem_op_e'(2'(1 + $unsigned($random(seed)) % 3));
   endtask

   // one full command, the next one starts only after its response is done
   task automatic send_cmd(input maskmem_cmd_s c);
      maskmem_rsp_s r;
      int gap;
      gap = $unsigned($random(seed)) % (max_gap + 1);
      repeat (gap) @(posedge clk);
      @(posedge clk);
      cmd <= c;
      cmd_req <= 1'b1;
      @(negedge clk);
      while (!cmd_ack)
         @(negedge clk);
      model_apply(c, r);
      @(posedge clk);
      cmd_req <= 1'b0;
      exp_push <= 1'b1;
      exp_rsp <= r;
      @(posedge clk);
      exp_push <= 1'b0;
      @(negedge clk);
      while (cmd_ack || !rsp_req)
         @(negedge clk);
      while (rsp_req || rsp_ack)
         @(negedge clk);
      n_sent++;
   endtask

   task automatic read_touched();
      maskmem_cmd_s c;
      foreach (touched_q[k])
      begin
         rand_cmd(OP_READ, c);
         c.addr = touched_q[k];
         send_cmd(c);
      end
      touched_q.delete();
   endtask

   task automatic report_test(input int num, input string name, input int cmds0,
                              input int errs0);
      $display("test %0d, %s: %0d commands, %0d errors", num, name, n_sent - cmds0,
               err_cnt - errs0);
   endtask

   // response consumer with a random delay before each ack
   initial
   begin : ack_proc
      int delay;
      rsp_ack = 1'b0;
      forever
      begin
         @(negedge clk);
         if (rsp_req)
         begin
            delay = $unsigned($random(seed)) % (max_ack_delay + 1);
            repeat (delay) @(posedge clk);
            @(posedge clk);
            rsp_ack <= 1'b1;
            @(negedge clk);
            while (rsp_req)
               @(negedge clk);
            @(posedge clk);
            rsp_ack <= 1'b0;
         end
      end
   end

   initial
   begin : timeout_proc
      cycle_cnt = 0;
      while (cycle_cnt < timeout_limit)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("timeout: no end of the run after %0d cycles", timeout_limit);
      $display("test failed");
      $finish;
   end

   initial
   begin : main_proc
      maskmem_cmd_s c;
      maskmem_op_e op;
      logic [31:0] rnd;
      int cmds0;
      int errs0;
      cmd_req = 1'b0;
      cmd = '0;
      exp_push = 1'b0;
      exp_rsp = '0;
      end_check = 1'b0;
      reset = 1'b1;
      max_gap = 2;
      max_ack_delay = 3;
      n_sent = 0;
      model_last = '0;
      repeat (reset_cycles) @(posedge clk);
      reset <= 1'b0;

      // the array is not cleared by reset, so every word gets a full-mask write first
      cmds0 = n_sent;
      errs0 = err_cnt;
      for (int a = 0; a < MASKMEM_DEPTH; a++)
      begin
         rand_cmd(OP_WRITE, c);
         c.addr = MASKMEM_ADDR_W'(a);
         c.mask = '1;
         send_cmd(c);
      end
      for (int i = 0; i < n_reads_after_fill; i++)
      begin
         rand_cmd(OP_READ, c);
         send_cmd(c);
      end
      report_test(1, "reset state", cmds0, errs0);

      cmds0 = n_sent;
      errs0 = err_cnt;
      for (int i = 0; i < n_masked; i++)
      begin
         rand_cmd(OP_WRITE, c);
         touched_q.push_back(c.addr);
         send_cmd(c);
      end
      read_touched();
      report_test(2, "masked write", cmds0, errs0);

      cmds0 = n_sent;
      errs0 = err_cnt;
      for (int i = 0; i < n_set_clear; i++)
      begin
         rnd = $random(seed);
         rand_cmd(rnd[0] ? OP_SET : OP_CLEAR, c);
         touched_q.push_back(c.addr);
         send_cmd(c);
      end
      read_touched();
      report_test(3, "set and clear", cmds0, errs0);

      // a read every fourth command, the others must report its data
      cmds0 = n_sent;
      errs0 = err_cnt;
      for (int i = 0; i < n_hold; i++)
      begin
         pick_op(i % 4 == 0, op);
         if (i % 4 == 0)
            op = OP_READ;
         rand_cmd(op, c);
         send_cmd(c);
      end
      report_test(4, "last-read hold", cmds0, errs0);

      cmds0 = n_sent;
      errs0 = err_cnt;
      max_ack_delay = 20;
      for (int i = 0; i < n_backpressure; i++)
      begin
         pick_op(1'b1, op);
         rand_cmd(op, c);
         send_cmd(c);
      end
      max_ack_delay = 3;
      report_test(5, "back-pressure", cmds0, errs0);

      cmds0 = n_sent;
      errs0 = err_cnt;
      max_gap = 4;
      for (int i = 0; i < n_mix; i++)
      begin
         pick_op(1'b1, op);
         rand_cmd(op, c);
         send_cmd(c);
      end
      report_test(6, "random mix", cmds0, errs0);

      @(posedge clk);
      end_check <= 1'b1;
      repeat (2) @(negedge clk);
      $display("6 tests, %0d commands sent, %0d acknowledged, %0d responses, %0d errors",
               n_sent, cmd_cnt, rsp_cnt, err_cnt);
      if (err_cnt == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule

// File: maskmem.f
verilog/maskmem_pkg.sv
verilog/maskmem_sram.sv
verilog/maskmem_cmd_port.sv
verilog/maskmem_op_unit.sv
verilog/maskmem_rsp_port.sv
verilog/maskmem_top.sv
sim/maskmem_checker.sv
sim/maskmem_tb.sv

// File: Makefile
# maskmem simulation with Verilator

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing -f maskmem.f --top-module maskmem_tb -o maskmem_sim
	./obj_dir/maskmem_sim | tee $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
